//--- src/rx_pkg.sv
package rx_pkg;

	// ========================================================================
	// receive side types
	// ========================================================================

	typedef logic [7:0] byte_t;     // one data byte
	typedef logic [7:0] addr_t;     // payload byte address
	typedef logic [8:0] len_t;      // payload length, 0..255
	typedef logic [2:0] copy_id_t;  // copy number, 0 is none

	localparam int NUM_COPIES = 5;

	typedef logic [NUM_COPIES-1:0] copy_mask_t;  // bit n is copy n+1

	// one write into the copy buffers
	typedef struct packed {
		logic     en;
		copy_id_t copy;
		addr_t    addr;
		byte_t    data;
	} wr_req_t;

	// end of a stored frame
	typedef struct packed {
		logic     valid;
		copy_id_t copy;
		len_t     len;
	} frame_end_t;

endpackage

//--- src/vote_pkg.sv
package vote_pkg;

	import rx_pkg::*;

	localparam int NUM_PAIRS = NUM_COPIES * (NUM_COPIES - 1) / 2;

	typedef logic [NUM_PAIRS-1:0] pair_mask_t;        // 12, 13, 14, 15, 23 .. 45
	typedef byte_t [NUM_COPIES-1:0] copy_bytes_t;      // one byte per buffer

	typedef struct packed {
		logic     done;
		logic     lost;
		logic     found;
		copy_id_t winner;
	} vote_result_t;

	// bit position of pair (a, b) in a pair_mask_t, copies counted from 0
	function automatic int pair_index(int a, int b);
		int lo;
		int hi;
		int idx;
		lo = (a < b) ? a : b;
		hi = (a < b) ? b : a;
		idx = 0;
		for (int i = 0; i < lo; i++)
			idx += NUM_COPIES - 1 - i;  // pairs that start below lo
		return (lo == hi) ? 0 : idx + hi - lo - 1;
	endfunction

endpackage

//--- src/frame_capture.sv
module frame_capture #(
	parameter int ID_OFFSET = 22
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               rx_en,
	input  rx_pkg::byte_t      rx_data,
	input  logic               capture_en,
	output rx_pkg::wr_req_t    wr_req,
	output rx_pkg::frame_end_t frame_end
);
	import rx_pkg::*;

	localparam int CNT_W = $clog2(ID_OFFSET + 2);

	logic             en_q;
	byte_t            data_q;
	logic [CNT_W-1:0] cnt;       // saturates one past the id byte
	logic             keep;      // frame accepted at its first byte
	logic             keep_now;
	logic             id_ok;
	copy_id_t         id;        // 0 while no valid id seen
	len_t             pay_len;   // also the next write address

	assign keep_now = (cnt == '0) ? capture_en : keep;
	assign id_ok = (data_q[3:0] != 4'd0) && (data_q[3:0] <= 4'(NUM_COPIES));

	always_ff @(posedge clk) begin
		data_q <= rx_data;
	end

	// ========================================================================
	// byte counting, id detect, buffer writes
	// ========================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_q      <= 1'b0;
			cnt       <= '0;
			keep      <= 1'b0;
			id        <= '0;
			pay_len   <= '0;
			wr_req    <= '0;
			frame_end <= '0;
		end else begin
			en_q            <= rx_en;
			wr_req.en       <= 1'b0;
			frame_end.valid <= 1'b0;
			if (en_q) begin
				keep <= keep_now;
				if (cnt <= CNT_W'(ID_OFFSET))
					cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(ID_OFFSET))
					id <= (keep_now && id_ok) ? data_q[2:0] : '0;  // high nibble ignored
				if (cnt == CNT_W'(ID_OFFSET + 1) && id != '0 && pay_len != len_t'(255)) begin
					wr_req.en   <= 1'b1;
					wr_req.copy <= id;
					wr_req.addr <= addr_t'(pay_len);
					wr_req.data <= data_q;
					pay_len     <= pay_len + 1'b1;
				end
			end else if (cnt != '0) begin
				// rx_en just fell
				frame_end.valid <= (id != '0) && (pay_len != '0);
				frame_end.copy  <= id;
				frame_end.len   <= pay_len;
				cnt             <= '0;
				id              <= '0;
				pay_len         <= '0;
			end
		end
	end

endmodule

//--- src/copy_store.sv
module copy_store (
	input  logic                  clk,
	input  rx_pkg::wr_req_t       wr_req,
	input  rx_pkg::addr_t         scan_addr,
	input  rx_pkg::copy_id_t      rd_copy,
	input  rx_pkg::addr_t         rd_addr,
	output vote_pkg::copy_bytes_t scan_bytes,
	output rx_pkg::byte_t         rd_byte
);
	import rx_pkg::*;

	localparam int DEPTH = 2 ** $bits(addr_t);

	byte_t    mem [NUM_COPIES][DEPTH];  // one buffer per copy
	copy_id_t wr_slot;
	copy_id_t rd_slot;

	assign wr_slot = wr_req.copy - 3'd1;
	assign rd_slot = (rd_copy != '0) ? rd_copy - 3'd1 : '0;  // idle reads go to copy 1

	always_ff @(posedge clk) begin
		if (wr_req.en)
			mem[wr_slot][wr_req.addr] <= wr_req.data;
	end

	// scan port, all buffers at the same address
	always_ff @(posedge clk) begin
		for (int c = 0; c < NUM_COPIES; c++)
			scan_bytes[c] <= mem[c][scan_addr];
	end

	// replay port
	always_ff @(posedge clk) begin
		rd_byte <= mem[rd_slot][rd_addr];
	end

endmodule

//--- src/pair_compare.sv
module pair_compare (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  scan_clear,
	input  logic                                  scan_run,
	input  rx_pkg::addr_t                         scan_addr,
	input  vote_pkg::copy_bytes_t                 scan_bytes,
	input  rx_pkg::len_t [rx_pkg::NUM_COPIES-1:0] lens,
	input  rx_pkg::copy_mask_t                    received,
	output vote_pkg::pair_mask_t                  agree
);
	import rx_pkg::*;
	import vote_pkg::*;

	logic  run_q;   // lines up with scan_bytes
	addr_t addr_q;
	len_t  pos;

	assign pos = len_t'(addr_q);

	always_ff @(posedge clk) begin
		if (!rst_n)
			run_q <= 1'b0;
		else
			run_q <= scan_run;
	end

	always_ff @(posedge clk) begin
		addr_q <= scan_addr;
	end

	// one compare slice per copy pair
	for (genvar a = 0; a < NUM_COPIES; a++) begin : g_a
		for (genvar b = a + 1; b < NUM_COPIES; b++) begin : g_b
			localparam int P = pair_index(a, b);

			logic same;    // no differing byte seen in this scan
			logic in_len;

			assign in_len = (pos < lens[a]) && (pos < lens[b]);

			always_ff @(posedge clk) begin
				if (!rst_n || scan_clear)
					same <= 1'b1;
				else if (run_q && in_len && (scan_bytes[a] != scan_bytes[b]))
					same <= 1'b0;
			end

			assign agree[P] = received[a] && received[b] && (lens[a] == lens[b]) && same;
		end
	end

endmodule

//--- src/vote_ctrl.sv
module vote_ctrl #(
	parameter int MIN_AGREE = 3
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  rx_pkg::frame_end_t                    frame_end,
	input  vote_pkg::pair_mask_t                  agree,
	output logic                                  capture_en,
	output logic                                  scan_clear,
	output logic                                  scan_run,
	output rx_pkg::addr_t                         scan_addr,
	output rx_pkg::len_t [rx_pkg::NUM_COPIES-1:0] lens,
	output rx_pkg::copy_mask_t                    received,
	output vote_pkg::vote_result_t                result,
	output rx_pkg::len_t                          winner_len
);
	import rx_pkg::*;
	import vote_pkg::*;

	typedef enum logic [2:0] {
		S_COLLECT,
		S_CLEAR,
		S_SCAN,
		S_DRAIN,
		S_DECIDE,
		S_REPLAY
	} state_t;

	state_t   state;
	len_t     max_len;      // scan length
	len_t     wait_cnt;     // replay time left
	logic     close_group;
	logic     found;
	copy_id_t winner;
	len_t     pick_len;

	assign close_group = frame_end.valid && (frame_end.copy == copy_id_t'(NUM_COPIES));
	assign capture_en  = (state == S_COLLECT) && !close_group;  // also drops a frame starting now
	assign scan_clear  = (state == S_CLEAR);
	assign scan_run    = (state == S_SCAN);

	// ========================================================================
	// winner choice, lowest copy with enough partners
	// ========================================================================

	always_comb begin
		int votes;
		found  = 1'b0;
		winner = '0;
		for (int c = NUM_COPIES - 1; c >= 0; c--) begin
			votes = 0;
			for (int o = 0; o < NUM_COPIES; o++) begin
				if (o != c && agree[pair_index(c, o)])
					votes++;
			end
			if (received[c] && votes >= MIN_AGREE - 1) begin
				found  = 1'b1;
				winner = copy_id_t'(c + 1);  // later passes hold lower copies
			end
		end
	end

	assign pick_len = found ? lens[winner - 3'd1] : '0;

	// ========================================================================
	// group and scan sequencing
	// ========================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_COLLECT;
			received  <= '0;
			max_len   <= '0;
			scan_addr <= '0;
			wait_cnt  <= '0;
			result    <= '0;
		end else begin
			result <= '0;
			case (state)
				S_COLLECT: begin
					if (frame_end.valid) begin
						received[frame_end.copy - 3'd1] <= 1'b1;
						if (frame_end.len > max_len)
							max_len <= frame_end.len;
						if (close_group)
							state <= S_CLEAR;
					end
				end
				S_CLEAR: begin
					scan_addr <= '0;
					state     <= S_SCAN;
				end
				S_SCAN: begin
					if (len_t'(scan_addr) == max_len - 1'b1)
						state <= S_DRAIN;
					else
						scan_addr <= scan_addr + 1'b1;
				end
				S_DRAIN: state <= S_DECIDE;  // last bytes still in flight
				S_DECIDE: begin
					result.done   <= 1'b1;
					result.lost   <= !(&agree);
					result.found  <= found;
					result.winner <= winner;
					wait_cnt      <= pick_len + len_t'(2);
					received      <= '0;
					max_len       <= '0;
					state         <= found ? S_REPLAY : S_COLLECT;
				end
				S_REPLAY: begin
					if (wait_cnt == '0)
						state <= S_COLLECT;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				default: state <= S_COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_COLLECT && frame_end.valid)
			lens[frame_end.copy - 3'd1] <= frame_end.len;
		if (state == S_DECIDE)
			winner_len <= pick_len;
	end

endmodule

//--- src/replay_sender.sv
module replay_sender (
	input  logic                   clk,
	input  logic                   rst_n,
	input  vote_pkg::vote_result_t result,
	input  rx_pkg::len_t           winner_len,
	input  rx_pkg::byte_t          rd_byte,
	output rx_pkg::copy_id_t       rd_copy,
	output rx_pkg::addr_t          rd_addr,
	output rx_pkg::byte_t          data_out,
	output logic                   out_valid
);
	import rx_pkg::*;

	logic     start;
	logic     active;     // reads after the first one
	addr_t    addr_cnt;
	addr_t    last_addr;
	copy_id_t copy_q;
	logic     rd_valid;   // rd_byte holds a payload byte

	assign start   = result.done && result.found;
	assign rd_copy = start ? result.winner : copy_q;  // address 0 goes out on done
	assign rd_addr = active ? addr_cnt : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active    <= 1'b0;
			addr_cnt  <= '0;
			rd_valid  <= 1'b0;
			out_valid <= 1'b0;
			data_out  <= '0;
		end else begin
			rd_valid  <= start || active;
			out_valid <= rd_valid;
			data_out  <= rd_valid ? rd_byte : '0;
			if (start) begin
				addr_cnt <= addr_t'(1);
				active   <= (winner_len > len_t'(1));
			end else if (active) begin
				if (addr_cnt == last_addr)
					active <= 1'b0;
				addr_cnt <= addr_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			copy_q    <= result.winner;
			last_addr <= addr_t'(winner_len - 1'b1);
		end
	end

endmodule

//--- src/redundant_rx_top.sv
module redundant_rx_top #(
	parameter int ID_OFFSET = 22,
	parameter int MIN_AGREE = 3
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          rx_en,
	input  rx_pkg::byte_t rx_data,
	output rx_pkg::byte_t data_out,
	output logic          out_valid,
	output logic          vote_done,
	output logic          lost
);
	import rx_pkg::*;
	import vote_pkg::*;

	wr_req_t                 wr_req;
	frame_end_t              frame_end;
	logic                    capture_en;
	logic                    scan_clear;
	logic                    scan_run;
	addr_t                   scan_addr;
	copy_bytes_t             scan_bytes;
	len_t [NUM_COPIES-1:0]   lens;
	copy_mask_t              received;
	pair_mask_t              agree;
	vote_result_t            result;
	len_t                    winner_len;
	copy_id_t                rd_copy;
	addr_t                   rd_addr;
	byte_t                   rd_byte;

	assign vote_done = result.done;
	assign lost      = result.lost;  // same cycle as vote_done

	// ========================================================================
	// receive, store, compare, vote, replay
	// ========================================================================

	frame_capture #(.ID_OFFSET(ID_OFFSET)) u_capture (
		.clk, .rst_n, .rx_en, .rx_data, .capture_en, .wr_req, .frame_end
	);

	copy_store u_store (
		.clk, .wr_req, .scan_addr, .rd_copy, .rd_addr, .scan_bytes, .rd_byte
	);

	pair_compare u_compare (
		.clk, .rst_n, .scan_clear, .scan_run, .scan_addr, .scan_bytes,
		.lens, .received, .agree
	);

	vote_ctrl #(.MIN_AGREE(MIN_AGREE)) u_vote (
		.clk, .rst_n, .frame_end, .agree, .capture_en, .scan_clear, .scan_run,
		.scan_addr, .lens, .received, .result, .winner_len
	);

	replay_sender u_replay (
		.clk, .rst_n, .result, .winner_len, .rd_byte,
		.rd_copy, .rd_addr, .data_out, .out_valid
	);

endmodule

//--- tests/redundant_rx_props.sv
module redundant_rx_props (
	input logic clk,
	input logic rst_n,
	input logic capture_en,
	input logic out_valid,
	input logic vote_done,
	input logic lost
);
	timeunit 1ns;
	timeprecision 1ps;

	// ========================================================================
	// result pulse and replay window
	// ========================================================================

	done_one_cycle: assert property (
		@(posedge clk) disable iff (!rst_n) vote_done |=> !vote_done
	) else $error("vote_done stayed high for more than one cycle");

	lost_with_done: assert property (
		@(posedge clk) disable iff (!rst_n) lost |-> vote_done
	) else $error("lost is high without vote_done");

	// capture_en is high only while the vote FSM collects copies
	no_output_in_collect: assert property (
		@(posedge clk) disable iff (!rst_n) out_valid |-> !capture_en
	) else $error("out_valid is high while copies are being collected");

	quiet_in_reset: assert property (
		@(posedge clk) !rst_n |=> (!out_valid && !vote_done && !lost)
	) else $error("outputs are not low during reset");

endmodule

//--- tests/redundant_rx_tb.sv
module redundant_rx_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rx_pkg::*;

	localparam int ID_OFFSET    = 4;   // short frames
	localparam int MIN_AGREE    = 3;
	localparam int MAX_GAP      = 4;
	localparam int NUM_GROUPS   = 16;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT  = RESET_CYCLES +
		NUM_GROUPS * (5 * (ID_OFFSET + 256 + MAX_GAP) + 2 * 256 + 20);

	logic  clk;
	logic  rst_n;
	logic  rx_en;
	byte_t rx_data;
	byte_t data_out;
	logic  out_valid;
	logic  vote_done;
	logic  lost;

	byte_t       copy_data [NUM_COPIES][256];  // model of each sent copy
	int          copy_len  [NUM_COPIES];
	bit          copy_sent [NUM_COPIES];
	logic [31:0] lfsr;
	int          errors;
	int          cycles;

	redundant_rx_top #(.ID_OFFSET(ID_OFFSET), .MIN_AGREE(MIN_AGREE)) uut (
		.clk(clk), .rst_n(rst_n), .rx_en(rx_en), .rx_data(rx_data),
		.data_out(data_out), .out_valid(out_valid), .vote_done(vote_done), .lost(lost)
	);

	bind redundant_rx_top redundant_rx_props u_props (
		.clk(clk), .rst_n(rst_n), .capture_en(capture_en),
		.out_valid(out_valid), .vote_done(vote_done), .lost(lost)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no end of test after %0d cycles", CYCLE_LIMIT);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped by timeout");
	end

	// ========================================================================
	// random source with taps 32 22 2 1
	// ========================================================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};  // one step per bit
		end
		return val;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// ========================================================================
	// frame stimulus
	// ========================================================================

	task automatic drive_frame(input byte_t bytes[$]);
		int gap;
		foreach (bytes[i]) begin
			@(posedge clk);
			rx_en   <= 1'b1;
			rx_data <= bytes[i];
		end
		gap = 1 + int'(take_bits(2));
		repeat (gap) begin
			@(posedge clk);
			rx_en <= 1'b0;
		end
	endtask

	// payload from copy c or random when c < 0
	task automatic send_frame(input logic [3:0] id, input int c, input int pay_len);
		byte_t bytes[$];
		for (int i = 0; i < ID_OFFSET; i++)
			bytes.push_back(byte_t'(take_bits(8)));
		bytes.push_back({4'(take_bits(4)), id});  // high nibble is noise
		for (int i = 0; i < pay_len; i++)
			bytes.push_back((c >= 0) ? copy_data[c][i] : byte_t'(take_bits(8)));
		drive_frame(bytes);
	endtask

	task automatic send_bad_frame(input int kind);
		byte_t bytes[$];
		int    n;
		case (kind)
			0: send_frame(4'd0, -1, 1 + int'(take_bits(4)));
			1: send_frame(4'd6, -1, 1 + int'(take_bits(4)));
			2: send_frame(4'd7, -1, 1 + int'(take_bits(4)));
			3: send_frame(4'd5, -1, 0);  // ends on the id byte
			default: begin
				n = 1 + int'(take_bits(2)) % ID_OFFSET;
				for (int i = 0; i < n; i++)
					bytes.push_back(byte_t'(take_bits(8)));
				drive_frame(bytes);
			end
		endcase
	endtask

	task automatic make_copies(input int len);
		byte_t b;
		for (int i = 0; i < 256; i++) begin
			b = byte_t'(take_bits(8));
			for (int c = 0; c < NUM_COPIES; c++)
				copy_data[c][i] = b;
		end
		for (int c = 0; c < NUM_COPIES; c++)
			copy_len[c] = len;
	endtask

	// ========================================================================
	// model and response checks
	// ========================================================================

	function automatic bit pair_agrees(input int a, input int b);
		if (!copy_sent[a] || !copy_sent[b] || copy_len[a] != copy_len[b])
			return 1'b0;
		for (int i = 0; i < copy_len[a]; i++)
			if (copy_data[a][i] != copy_data[b][i])
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic predict(output logic exp_lost, output logic exp_found, output int win);
		int votes;
		exp_lost  = 1'b0;
		exp_found = 1'b0;
		win       = 0;
		for (int a = 0; a < NUM_COPIES; a++)
			for (int b = a + 1; b < NUM_COPIES; b++)
				if (!pair_agrees(a, b))
					exp_lost = 1'b1;  // any pair apart or a copy missing
		for (int c = 0; c < NUM_COPIES && !exp_found; c++) begin
			votes = 0;
			for (int o = 0; o < NUM_COPIES; o++)
				if (o != c && pair_agrees(c, o))
					votes++;
			if (copy_sent[c] && votes >= MIN_AGREE - 1) begin
				exp_found = 1'b1;
				win       = c;
			end
		end
	endtask

	task automatic check_group();
		logic exp_lost;
		logic exp_found;
		logic exp_valid;
		int   win;
		int   exp_len;
		predict(exp_lost, exp_found, win);
		exp_len = exp_found ? copy_len[win] : 0;
		@(negedge clk);
		while (vote_done !== 1'b1)
			@(negedge clk);
		check_value("lost", 32'(lost), 32'(exp_lost));
		// replay starts two cycles after vote_done
		for (int k = 1; k < exp_len + 5; k++) begin
			@(negedge clk);
			exp_valid = (k >= 2) && (k < exp_len + 2);
			check_value("vote_done", 32'(vote_done), 32'h0);
			check_value("out_valid", 32'(out_valid), 32'(exp_valid));
			if (exp_valid)
				check_value("data_out", 32'(data_out), 32'(copy_data[win][k - 2]));
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic send_group(input logic [4:0] mask, input int bad_kind, input int bad_pos);
		for (int c = 0; c < NUM_COPIES; c++)
			copy_sent[c] = 1'b0;
		for (int c = 0; c < NUM_COPIES; c++) begin
			if (c == bad_pos)
				send_bad_frame(bad_kind);
			if (mask[c]) begin
				send_frame(4'(c + 1), c, copy_len[c]);
				copy_sent[c] = 1'b1;
			end
		end
		check_group();
	endtask

	initial begin
		int c;
		int pos;
		errors  = 0;
		lfsr    = 32'h17c9;
		rst_n   = 1'b0;
		rx_en   = 1'b0;
		rx_data = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);

		for (int g = 0; g < 3; g++) begin  // five equal copies
			make_copies(1 + int'(take_bits(6)));
			send_group(5'b11111, -1, -1);
		end
		make_copies(255);
		send_group(5'b11111, -1, -1);

		for (int g = 0; g < 2; g++) begin  // one byte corrupted
			make_copies(1 + int'(take_bits(6)));
			c = int'(take_bits(3)) % NUM_COPIES;
			pos = int'(take_bits(8)) % copy_len[c];
			copy_data[c][pos] = copy_data[c][pos] ^ byte_t'(1 + take_bits(7));
			send_group(5'b11111, -1, -1);
		end
		for (int g = 0; g < 2; g++) begin  // one length off
			make_copies(1 + int'(take_bits(6)));
			c = int'(take_bits(3)) % NUM_COPIES;
			copy_len[c] = copy_len[c] + 1;
			send_group(5'b11111, -1, -1);
		end

		make_copies(1 + int'(take_bits(6)));
		send_group(5'b10101, -1, -1);
		make_copies(1 + int'(take_bits(6)));
		send_group(5'b10001, -1, -1);

		make_copies(1 + int'(take_bits(6)));
		for (int k = 0; k < NUM_COPIES; k++)
			copy_data[k][0] = byte_t'(8'h10 + k);  // no two copies alike
		send_group(5'b11111, -1, -1);

		for (int k = 0; k < 5; k++) begin  // frames that must be ignored
			make_copies(1 + int'(take_bits(6)));
			send_group(5'b11111, k, int'(take_bits(3)) % NUM_COPIES);
		end

		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- sources.f
src/rx_pkg.sv
src/vote_pkg.sv
src/frame_capture.sv
src/copy_store.sv
src/pair_compare.sv
src/vote_ctrl.sv
src/replay_sender.sv
src/redundant_rx_top.sv
tests/redundant_rx_props.sv
tests/redundant_rx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the redundant receiver testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module redundant_rx_tb -Mdir obj_dir -o sim

./obj_dir/sim 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
